// File: include/fpdiv_defines.svh
`ifndef FPDIV_DEFINES_SVH
`define FPDIV_DEFINES_SVH

// mantissa incl. hidden bit
`define FPDIV_MANT_W 24

// biased exponent
`define FPDIV_EXP_W 8

// non-restoring cells evaluated per clock
`define FPDIV_CELLS 4

// clock steps per operation, CELLS * STEPS quotient bits
`define FPDIV_STEPS 6

`define FPDIV_EXP_BIAS 127

`endif

// File: hdl/fpDivPkg.sv
`include "fpdiv_defines.svh"

package fpDivPkg;

  //////////////////////////////////////////////////////////////////////
  // widths with a meaning
  //////////////////////////////////////////////////////////////////////

  typedef logic [`FPDIV_MANT_W-1:0]        mant_t;     // hidden bit set
  typedef logic [`FPDIV_MANT_W:0]          rem_t;      // one sign bit on top
  typedef logic [`FPDIV_MANT_W:0]          resMant_t;  // room for rounding carry
  typedef logic [`FPDIV_EXP_W-1:0]         exp_t;
  typedef logic signed [`FPDIV_EXP_W+1:0]  resExp_t;
  typedef logic [`FPDIV_CELLS-1:0]         quotBits_t; // cell 0 in the msb

  //////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    mant_t mantNum;
    mant_t mantDen;
    exp_t  expNum;
    exp_t  expDen;
  } divCmd_t;

  typedef struct packed {
    resMant_t mant;
    resExp_t  exp;
  } divRes_t;

  // remainder already doubled for the next cell, qBit picks sub (1) or add (0)
  typedef struct packed {
    rem_t rem;
    logic qBit;
  } cellLink_t;

  typedef enum logic [1:0] {
    IDLE,
    ITERATE,
    FINISH
  } ctrlState_t;

endpackage

// File: hdl/divIterCell.sv
`timescale 1ns/100ps

`include "fpdiv_defines.svh"

// one non-restoring division iteration, purely combinational
module divIterCell
(
  input  fpDivPkg::cellLink_t link,
  input  fpDivPkg::mant_t     divisor,
  output fpDivPkg::cellLink_t linkOut
);

  fpDivPkg::rem_t divExt;
  fpDivPkg::rem_t newRem;

  assign divExt = {1'b0, divisor};

  // wraps modulo 2^25, true result always lies in [-D, D)
  always_comb
  begin
    if (link.qBit)
    begin
      newRem = link.rem - divExt;
    end
    else
    begin
      newRem = link.rem + divExt;
    end
  end

  // quotient bit is the carry out, i.e. remainder not negative
  assign linkOut.qBit = ~newRem[`FPDIV_MANT_W];

  // doubled for the next cell, the lost msb is recovered by the wrap
  assign linkOut.rem = {newRem[`FPDIV_MANT_W-1:0], 1'b0};

endmodule

// File: hdl/divStepCtrl.sv
`timescale 1ns/100ps

`include "fpdiv_defines.svh"

module divStepCtrl
(
  input  logic                Clk_CI,
  input  logic                Rst_RBI,
  input  logic                Start,
  input  fpDivPkg::divCmd_t   Cmd,
  input  fpDivPkg::cellLink_t lastLink,   // output of the last cell
  output logic                Ready,
  output fpDivPkg::mant_t     divisor,
  output fpDivPkg::cellLink_t firstLink,
  output logic                stepEn,
  output logic                lastStep,
  output fpDivPkg::exp_t      expNum,
  output fpDivPkg::exp_t      expDen
);

  localparam int CntW = $clog2(`FPDIV_STEPS);

  fpDivPkg::ctrlState_t state;
  fpDivPkg::ctrlState_t stateNext;
  logic [CntW-1:0]      stepCnt;
  logic                 accept;

  fpDivPkg::divCmd_t    cmdQ;     // operand latch
  fpDivPkg::cellLink_t  remLink;  // partial remainder between steps

  assign accept   = Start & Ready;
  assign stepEn   = (state == fpDivPkg::ITERATE);
  assign lastStep = stepEn && (stepCnt == CntW'(`FPDIV_STEPS - 1));

  //////////////////////////////////////////////////////////////////////
  // step sequencing
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    stateNext = state;
    case (state)
      fpDivPkg::IDLE:
      begin
        if (accept)
        begin
          stateNext = fpDivPkg::ITERATE;
        end
      end
      fpDivPkg::ITERATE:
      begin
        if (lastStep)
        begin
          stateNext = fpDivPkg::FINISH;
        end
      end
      fpDivPkg::FINISH:
      begin
        stateNext = fpDivPkg::IDLE;   // assembler rounds here
      end
      default:
      begin
        stateNext = fpDivPkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      state   <= fpDivPkg::IDLE;
      stepCnt <= '0;
    end
    else
    begin
      state <= stateNext;
      if (stepEn)
      begin
        stepCnt <= lastStep ? '0 : stepCnt + 1'b1;
      end
    end
  end

  // low from the cycle after acceptance, high again with Done
  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      Ready <= 1'b1;
    end
    else if (accept)
    begin
      Ready <= 1'b0;
    end
    else if (state == fpDivPkg::FINISH)
    begin
      Ready <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // operands and partial remainder
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk_CI)
  begin
    if (accept)
    begin
      cmdQ <= Cmd;
    end
  end

  // numerator first, qBit set so cell 0 starts with N - D
  always_ff @(posedge Clk_CI)
  begin
    if (accept)
    begin
      remLink.rem  <= {1'b0, Cmd.mantNum};
      remLink.qBit <= 1'b1;
    end
    else if (stepEn)
    begin
      remLink <= lastLink;            // fed back from the last cell
    end
  end

  assign firstLink = remLink;
  assign divisor   = cmdQ.mantDen;
  assign expNum    = cmdQ.expNum;
  assign expDen    = cmdQ.expDen;

endmodule

// File: hdl/divResultAssemble.sv
`timescale 1ns/100ps

`include "fpdiv_defines.svh"

module divResultAssemble
(
  input  logic                Clk_CI,
  input  logic                Rst_RBI,
  input  logic                stepEn,
  input  logic                lastStep,
  input  fpDivPkg::quotBits_t quotBits,
  input  fpDivPkg::cellLink_t lastLink,
  input  fpDivPkg::mant_t     divisor,
  input  fpDivPkg::exp_t      expNum,
  input  fpDivPkg::exp_t      expDen,
  output logic                Done,
  output fpDivPkg::divRes_t   Res
);

  fpDivPkg::mant_t     quot;        // msb first
  fpDivPkg::cellLink_t guardLink;   // remainder after the last step
  logic                roundPend;

  fpDivPkg::rem_t      divExt;
  fpDivPkg::rem_t      guardRem;
  logic                guardBit;
  fpDivPkg::resMant_t  mantRound;
  fpDivPkg::resExp_t   expPre;

  //////////////////////////////////////////////////////////////////////
  // quotient collection
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk_CI)
  begin
    if (stepEn)
    begin
      quot <= {quot[`FPDIV_MANT_W-`FPDIV_CELLS-1:0], quotBits};
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (lastStep)
    begin
      guardLink <= lastLink;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // guard iteration and rounding
  //////////////////////////////////////////////////////////////////////

  assign divExt = {1'b0, divisor};

  always_comb
  begin
    if (guardLink.qBit)
    begin
      guardRem = guardLink.rem - divExt;
    end
    else
    begin
      guardRem = guardLink.rem + divExt;
    end
  end

  assign guardBit  = ~guardRem[`FPDIV_MANT_W];        // weight half an lsb
  assign mantRound = {1'b0, quot} + fpDivPkg::resMant_t'(guardBit);

  // en - ed + bias, both zero extended
  assign expPre = fpDivPkg::resExp_t'({2'b00, expNum})
                - fpDivPkg::resExp_t'({2'b00, expDen})
                + fpDivPkg::resExp_t'(`FPDIV_EXP_BIAS);

  //////////////////////////////////////////////////////////////////////
  // result register and done pulse
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      roundPend <= 1'b0;
      Done      <= 1'b0;
    end
    else
    begin
      roundPend <= lastStep;
      Done      <= roundPend;   // one cycle only
    end
  end

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      Res <= '0;
    end
    else if (roundPend)
    begin
      Res.mant <= mantRound;
      Res.exp  <= expPre;
    end
  end

endmodule

// File: hdl/fpDivTop.sv
`timescale 1ns/100ps

`include "fpdiv_defines.svh"

module fpDivTop
(
  input  logic              Clk_CI,
  input  logic              Rst_RBI,
  input  logic              Start,
  input  fpDivPkg::divCmd_t Cmd,
  output logic              Ready,
  output logic              Done,
  output fpDivPkg::divRes_t Res
);

  fpDivPkg::cellLink_t link [`FPDIV_CELLS+1];   // chain, link[0] from ctrl
  fpDivPkg::mant_t     divisor;
  fpDivPkg::quotBits_t quotBits;
  fpDivPkg::exp_t      expNum;
  fpDivPkg::exp_t      expDen;
  logic                stepEn;
  logic                lastStep;

  divStepCtrl i_ctrl
  (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .Start     (Start),
    .Cmd       (Cmd),
    .lastLink  (link[`FPDIV_CELLS]),
    .Ready     (Ready),
    .divisor   (divisor),
    .firstLink (link[0]),
    .stepEn    (stepEn),
    .lastStep  (lastStep),
    .expNum    (expNum),
    .expDen    (expDen)
  );

  //////////////////////////////////////////////////////////////////////
  // iteration cells, one quotient bit each
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `FPDIV_CELLS; i++)
  begin : g_cell
    divIterCell i_cell
    (
      .link    (link[i]),
      .divisor (divisor),
      .linkOut (link[i+1])
    );

    assign quotBits[`FPDIV_CELLS-1-i] = link[i+1].qBit;  // cell 0 is msb
  end

  divResultAssemble i_asm
  (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .stepEn   (stepEn),
    .lastStep (lastStep),
    .quotBits (quotBits),
    .lastLink (link[`FPDIV_CELLS]),
    .divisor  (divisor),
    .expNum   (expNum),
    .expDen   (expDen),
    .Done     (Done),
    .Res      (Res)
  );

endmodule

// File: bench/fpDivTb.sv
`timescale 1ns/100ps

`include "fpdiv_defines.svh"

module fpDivTb;

  localparam int MantW      = `FPDIV_MANT_W;
  localparam int Latency    = 7;             // accept edge to Done edge
  localparam int NumRandom  = 200;
  localparam int OpCycles   = 9;
  localparam int MaxOps     = 230;
  localparam int TimeoutCycles = 2 * MaxOps * OpCycles + 860;
  localparam logic [31:0] Seed = 32'hdecb28dc;

  logic              Clk_CI;
  logic              Rst_RBI;
  logic              Start;
  fpDivPkg::divCmd_t Cmd;
  logic              Ready;
  logic              Done;
  fpDivPkg::divRes_t Res;

  int cycleCnt = 0;
  int testCnt  = 0;
  int seqErr   = 0;   // found by the stimulus process
  int chkErr   = 0;   // found by the result checker

  // operations in flight, oldest first
  fpDivPkg::divRes_t expQ [$];
  string             nameQ [$];
  int                accQ [$];

  fpDivTop dut
  (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .Start   (Start),
    .Cmd     (Cmd),
    .Ready   (Ready),
    .Done    (Done),
    .Res     (Res)
  );

  initial
  begin
    Clk_CI = 1'b0;
    forever #5 Clk_CI = ~Clk_CI;
  end

  always @(posedge Clk_CI)
  begin
    cycleCnt <= cycleCnt + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // (N * 2^24 / D + 1) >> 1, exponent en - ed + bias
  function automatic fpDivPkg::divRes_t refDiv(input fpDivPkg::divCmd_t c);
    fpDivPkg::divRes_t r;
    logic [2*MantW-1:0] num;
    logic [2*MantW-1:0] quo;
    int                 e;
    num    = {c.mantNum, {MantW{1'b0}}};
    quo    = num / {{MantW{1'b0}}, c.mantDen};
    quo    = quo + 1;
    r.mant = quo[MantW+1:1];
    e      = int'(c.expNum) - int'(c.expDen) + `FPDIV_EXP_BIAS;
    r.exp  = e[9:0];
    return r;
  endfunction

  function automatic fpDivPkg::divCmd_t makeCmd(input fpDivPkg::mant_t n,
                                                input fpDivPkg::mant_t d,
                                                input fpDivPkg::exp_t en,
                                                input fpDivPkg::exp_t ed);
    fpDivPkg::divCmd_t c;
    c.mantNum = n;
    c.mantDen = d;
    c.expNum  = en;
    c.expDen  = ed;
    return c;
  endfunction

  function automatic fpDivPkg::divCmd_t randomCmd();
    fpDivPkg::divCmd_t c;
    c.mantNum = fpDivPkg::mant_t'($urandom);
    c.mantDen = fpDivPkg::mant_t'($urandom);
    c.mantNum[MantW-1] = 1'b1;   // hidden bits
    c.mantDen[MantW-1] = 1'b1;
    c.expNum  = fpDivPkg::exp_t'($urandom);
    c.expDen  = fpDivPkg::exp_t'($urandom);
    return c;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // result checker
  //////////////////////////////////////////////////////////////////////

  always @(negedge Clk_CI)
  begin
    fpDivPkg::divRes_t want;
    string             name;
    int                acc;
    if (Rst_RBI && Done === 1'b1)
    begin
      if (expQ.size() == 0)
      begin
        chkErr = chkErr + 1;
        $display("Done pulsed at cycle %0d with no operation in flight", cycleCnt);
      end
      else
      begin
        want = expQ.pop_front();
        name = nameQ.pop_front();
        acc  = accQ.pop_front();
        testCnt = testCnt + 1;
        if (Ready !== 1'b1)
        begin
          chkErr = chkErr + 1;
          $display("%s: Ready did not rise together with Done", name);
        end
        if (Res !== want)
        begin
          chkErr = chkErr + 1;
          $display("error %s expected mant %h exp %0d actual mant %h exp %0d",
                   name, want.mant, $signed(want.exp), Res.mant, $signed(Res.exp));
        end
        else if (cycleCnt - acc != Latency)
        begin
          chkErr = chkErr + 1;
          $display("%s: Done came %0d cycles after acceptance instead of %0d",
                   name, cycleCnt - acc, Latency);
        end
        else
        begin
          $display("pass %s", name);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks, each entered and left just after a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic startOp(input fpDivPkg::divCmd_t c, input string name);
    while (Ready !== 1'b1)
    begin
      @(negedge Clk_CI);
    end
    Start = 1'b1;
    Cmd   = c;
    expQ.push_back(refDiv(c));
    nameQ.push_back(name);
    accQ.push_back(cycleCnt + 1);   // taken at the coming rising edge
    @(negedge Clk_CI);
    Start = 1'b0;
    if (Ready !== 1'b0)
    begin
      seqErr = seqErr + 1;
      $display("%s: Ready still high after the operation was accepted", name);
    end
  endtask

  // Ready stays low while busy
  task automatic waitForDone();
    bit earlyReady;
    earlyReady = 1'b0;
    while (Done !== 1'b1)
    begin
      if (Ready !== 1'b0 && !earlyReady)
      begin
        earlyReady = 1'b1;
        seqErr     = seqErr + 1;
        $display("Ready went high at cycle %0d before Done", cycleCnt);
      end
      @(negedge Clk_CI);
    end
  endtask

  task automatic runOp(input fpDivPkg::divCmd_t c, input string name);
    startOp(c, name);
    waitForDone();
  endtask

  task automatic checkResetState();
    testCnt = testCnt + 1;
    if (Ready !== 1'b1 || Done !== 1'b0 || Res !== '0)
    begin
      seqErr = seqErr + 1;
      $display("error reset expected ready 1 done 0 res %h actual ready %b done %b res %h",
               fpDivPkg::divRes_t'(0), Ready, Done, Res);
    end
    else
    begin
      $display("pass reset");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int                holdErr;
    fpDivPkg::divRes_t held;
    fpDivPkg::divRes_t badRes;
    void'($urandom(Seed));
    Rst_RBI = 1'b0;
    Start   = 1'b0;
    Cmd     = '0;

    repeat (3) @(negedge Clk_CI);
    checkResetState();
    Rst_RBI = 1'b1;
    @(negedge Clk_CI);

    // directed corners
    runOp(makeCmd(24'h800000, 24'h800000, 8'd127, 8'd127), "equalMant");
    runOp(makeCmd(24'hffffff, 24'h800000, 8'd130, 8'd3), "maxOverMin");
    runOp(makeCmd(24'hffffff, 24'h800001, 8'd1, 8'd1), "nearTwo");
    runOp(makeCmd(24'h800000, 24'hffffff, 8'd64, 8'd200), "minOverMax");
    runOp(makeCmd(24'hc00000, 24'ha00000, 8'd0, 8'd255), "expLow");
    runOp(makeCmd(24'ha00000, 24'hc00000, 8'd255, 8'd0), "expHigh");

    for (int i = 0; i < NumRandom; i++)
    begin
      runOp(randomCmd(), $sformatf("rand%0d", i));
    end

    // Start while busy must be dropped
    startOp(makeCmd(24'hd55555, 24'h9abcde, 8'd100, 8'd90), "ignoreBusy");
    Cmd   = makeCmd(24'h812345, 24'hfedcba, 8'd10, 8'd20);
    Start = 1'b1;
    repeat (3) @(negedge Clk_CI);
    Start = 1'b0;
    waitForDone();
    repeat (10) @(negedge Clk_CI);   // checker flags any stray Done

    // restart right after Done, old result held meanwhile
    runOp(makeCmd(24'hb00000, 24'he00000, 8'd140, 8'd120), "holdFirst");
    held    = Res;
    badRes  = Res;
    holdErr = 0;
    startOp(makeCmd(24'hf0f0f0, 24'h8f8f8f, 8'd50, 8'd60), "holdSecond");
    while (Done !== 1'b1)
    begin
      if (Res !== held && holdErr == 0)
      begin
        holdErr = holdErr + 1;
        badRes  = Res;
      end
      @(negedge Clk_CI);
    end
    testCnt = testCnt + 1;
    if (holdErr != 0)
    begin
      seqErr = seqErr + 1;
      $display("error holdRes expected %h actual %h", held, badRes);
    end
    else
    begin
      $display("pass holdRes");
    end

    repeat (4) @(negedge Clk_CI);
    if (expQ.size() != 0)
    begin
      seqErr = seqErr + 1;
      $display("%0d accepted operations never signalled Done", expQ.size());
    end

    $display("tests %0d, errors %0d", testCnt, seqErr + chkErr);
    if (seqErr + chkErr == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial
  begin
    while (cycleCnt < TimeoutCycles)
    begin
      @(posedge Clk_CI);
    end
    $display("run did not finish within %0d cycles", TimeoutCycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
hdl/fpDivPkg.sv
hdl/divIterCell.sv
hdl/divStepCtrl.sv
hdl/divResultAssemble.sv
hdl/fpDivTop.sv
bench/fpDivTb.sv

// File: run.sh
#!/bin/sh
# build and run the divider testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  -f sim.f \
  --top-module fpDivTb \
  -o fpDivSim

./obj_dir/fpDivSim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
  echo "simulation failed"
  exit 1
fi

if ! grep -q "Test OK" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
exit 0
